// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_top -f sources.f -o tb_top_sim
./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi

// File: source/cache_ctrl.sv
// Cache controller: sequences each request through lookup, fill or write, and response.
`timescale 1ns/1ps

module cache_ctrl import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,
    input  op_e               op_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [WORD_W-1:0] wdata_i,
    input  logic              lk_hit_i,
    input  logic [WAY_W-1:0]  lk_hit_way_i,
    input  logic [WAY_W-1:0]  lk_victim_i,
    input  logic [WORD_W-1:0] st_data_i,
    input  logic              mp_done_i,
    input  logic [LINE_W-1:0] mp_line_i,
    output logic              done_o,
    output logic [WORD_W-1:0] rdata_o,
    output logic              hit_o,
    output logic              lk_lookup_o,
    output logic              lk_fill_o,
    output logic              lk_inval_o,
    output logic [WAY_W-1:0]  lk_way_o,
    output logic [TAG_W-1:0]  lk_tag_o,
    output logic              st_fill_o,
    output logic [WAY_W-1:0]  st_way_o,
    output logic [OFFS_W-1:0] st_offs_o,
    output logic [LINE_W-1:0] st_line_o,
    output logic              mp_fetch_o,
    output logic              mp_write_o,
    output logic [ADDR_W-1:0] mp_addr_o,
    output logic [WORD_W-1:0] mp_wdata_o
);

    typedef enum logic [2:0] {
        S_LOOKUP,     // Waits for start and decides hit or miss.
        S_FETCH_WAIT,
        S_INSTALL,
        S_RESPOND,
        S_WRITE_WAIT
    } cstate_e;

    cstate_e         state_q;
    logic [WAY_W-1:0] victim_q;
    logic            is_read;
    logic            decide;

    assign is_read = (op_i != OP_WR_WORD);
    assign decide  = (state_q == S_LOOKUP) && start_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobes and selects toward tag store, line store and memory port.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign lk_lookup_o = decide && is_read;             // Touches a hit way.
    assign lk_inval_o  = decide && !is_read && lk_hit_i;
    assign lk_fill_o   = (state_q == S_INSTALL);
    assign lk_way_o    = (state_q == S_INSTALL) ? victim_q : lk_hit_way_i;
    assign lk_tag_o    = addr_i[ADDR_W-1:OFFS_W];

    assign st_fill_o = (state_q == S_INSTALL);
    assign st_way_o  = (state_q == S_LOOKUP) ? lk_hit_way_i : victim_q;
    assign st_offs_o = addr_i[OFFS_W-1:0];
    assign st_line_o = mp_line_i; // Held by the memory port after the fetch.

    // Fetches are line aligned, writes carry the word address.
    assign mp_addr_o  = is_read ? {addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}} : addr_i;
    assign mp_wdata_o = wdata_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= S_LOOKUP;
            done_o     <= 1'b0;
            mp_fetch_o <= 1'b0;
            mp_write_o <= 1'b0;
        end else begin
            done_o     <= 1'b0;
            mp_fetch_o <= 1'b0;
            mp_write_o <= 1'b0;
            case (state_q)
                S_LOOKUP: begin
                    if (decide && is_read && lk_hit_i) begin
                        done_o <= 1'b1; // Hit answers straight away.
                    end else if (decide && is_read) begin
                        mp_fetch_o <= 1'b1;
                        state_q    <= S_FETCH_WAIT;
                    end else if (decide) begin
                        mp_write_o <= 1'b1;
                        state_q    <= S_WRITE_WAIT;
                    end
                end
                S_FETCH_WAIT: begin
                    if (mp_done_i) begin
                        state_q <= S_INSTALL;
                    end
                end
                S_INSTALL: begin
                    state_q <= S_RESPOND;
                end
                S_RESPOND: begin
                    done_o  <= 1'b1;
                    state_q <= S_LOOKUP;
                end
                default: begin
                    if (mp_done_i) begin
                        done_o  <= 1'b1; // Write reached memory.
                        state_q <= S_LOOKUP;
                    end
                end
            endcase
        end
    end

    // Response payload and the chosen victim.
    always_ff @(posedge clk_i) begin
        if (decide) begin
            hit_o    <= lk_hit_i;
            victim_q <= lk_victim_i;
        end
        if (decide || state_q == S_RESPOND) begin
            rdata_o <= st_data_i;
        end
    end

endmodule

// File: source/cache_geom_pkg.sv
// Cache geometry package: address split, way count and request kinds.

package cache_geom_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address split: tag | offset.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ADDR_W = 20;              // Byte address.
    localparam int OFFS_W = 4;               // Byte offset in a line.
    localparam int TAG_W  = ADDR_W - OFFS_W; // Upper address bits.

    localparam int NUM_WAYS = 4;
    localparam int WAY_W    = 2;

    // Processor request kinds.
    typedef enum logic [1:0] {
        OP_RD_WORD = 2'b00,
        OP_RD_BYTE = 2'b01,
        OP_WR_WORD = 2'b10
    } op_e;

endpackage

// File: source/cache_top.sv
// Cache top level: connects the processor port, controller, tag and line stores, memory port.
`timescale 1ns/1ps

module cache_top import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_i,
    input  op_e               op_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [WORD_W-1:0] wdata_i,
    output logic              ack_o,
    output logic [WORD_W-1:0] rdata_o,
    output logic              hit_o,
    output logic              unalign_o,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [WORD_W-1:0] mem_wdata_o,
    input  logic              mem_ack_i,
    input  logic [LINE_W-1:0] mem_line_i
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal nets.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic              cp_start;
    op_e               cp_op;
    logic [ADDR_W-1:0] cp_addr;
    logic [WORD_W-1:0] cp_wdata;

    logic              ctl_done;
    logic [WORD_W-1:0] ctl_rdata;
    logic              ctl_hit;

    logic              lk_lookup;
    logic              lk_fill;
    logic              lk_inval;
    logic [WAY_W-1:0]  lk_way;
    logic [TAG_W-1:0]  lk_tag;
    logic              lk_hit;
    logic [WAY_W-1:0]  lk_hit_way;
    logic [WAY_W-1:0]  lk_victim;

    logic              st_fill;
    logic [WAY_W-1:0]  st_way;
    logic [OFFS_W-1:0] st_offs;
    logic [LINE_W-1:0] st_line;
    logic [WORD_W-1:0] st_data;

    logic              mp_fetch;
    logic              mp_write;
    logic [ADDR_W-1:0] mp_addr;
    logic [WORD_W-1:0] mp_wdata;
    logic              mp_done;
    logic [LINE_W-1:0] mp_line;

    cpu_port u_cpu_port (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .op_i       (op_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .done_i     (ctl_done),
        .rdata_i    (ctl_rdata),
        .hit_i      (ctl_hit),
        .ack_o      (ack_o),
        .rdata_o    (rdata_o),
        .hit_o      (hit_o),
        .unalign_o  (unalign_o),
        .start_o    (cp_start),
        .op_o       (cp_op),
        .addr_o     (cp_addr),
        .wdata_o    (cp_wdata),
        .misalign_o ()          // Same flag as unalign_o.
    );

    cache_ctrl u_cache_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (cp_start),
        .op_i         (cp_op),
        .addr_i       (cp_addr),
        .wdata_i      (cp_wdata),
        .lk_hit_i     (lk_hit),
        .lk_hit_way_i (lk_hit_way),
        .lk_victim_i  (lk_victim),
        .st_data_i    (st_data),
        .mp_done_i    (mp_done),
        .mp_line_i    (mp_line),
        .done_o       (ctl_done),
        .rdata_o      (ctl_rdata),
        .hit_o        (ctl_hit),
        .lk_lookup_o  (lk_lookup),
        .lk_fill_o    (lk_fill),
        .lk_inval_o   (lk_inval),
        .lk_way_o     (lk_way),
        .lk_tag_o     (lk_tag),
        .st_fill_o    (st_fill),
        .st_way_o     (st_way),
        .st_offs_o    (st_offs),
        .st_line_o    (st_line),
        .mp_fetch_o   (mp_fetch),
        .mp_write_o   (mp_write),
        .mp_addr_o    (mp_addr),
        .mp_wdata_o   (mp_wdata)
    );

    tag_lookup u_tag_lookup (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .addr_i    (cp_addr),
        .lookup_i  (lk_lookup),
        .fill_i    (lk_fill),
        .inval_i   (lk_inval),
        .way_i     (lk_way),
        .tag_i     (lk_tag),
        .hit_o     (lk_hit),
        .hit_way_o (lk_hit_way),
        .victim_o  (lk_victim)
    );

    line_store u_line_store (
        .clk_i  (clk_i),
        .fill_i (st_fill),
        .way_i  (st_way),
        .offs_i (st_offs),
        .byte_i (cp_op == OP_RD_BYTE),
        .line_i (st_line),
        .data_o (st_data)
    );

    mem_port u_mem_port (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .fetch_i     (mp_fetch),
        .write_i     (mp_write),
        .addr_i      (mp_addr),
        .wdata_i     (mp_wdata),
        .mem_ack_i   (mem_ack_i),
        .mem_line_i  (mem_line_i),
        .done_o      (mp_done),
        .line_o      (mp_line),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o)
    );

endmodule

// File: source/cpu_port.sv
// Processor port: four-phase slave that latches requests and checks alignment.
`timescale 1ns/1ps

module cpu_port import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_i,
    input  op_e               op_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [WORD_W-1:0] wdata_i,
    input  logic              done_i,
    input  logic [WORD_W-1:0] rdata_i,
    input  logic              hit_i,
    output logic              ack_o,
    output logic [WORD_W-1:0] rdata_o,
    output logic              hit_o,
    output logic              unalign_o,
    output logic              start_o,
    output op_e               op_o,
    output logic [ADDR_W-1:0] addr_o,
    output logic [WORD_W-1:0] wdata_o,
    output logic              misalign_o
);

    typedef enum logic [1:0] {P_IDLE, P_BUSY, P_ACK} pstate_e;

    pstate_e state_q;
    logic    misalign_q;
    logic    misalign_in;

    // Word accesses must sit on a 4-byte boundary.
    assign misalign_in = (op_i != OP_RD_BYTE) && (addr_i[1:0] != 2'b00);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= P_IDLE;
            start_o <= 1'b0;
        end else begin
            start_o <= 1'b0;
            case (state_q)
                P_IDLE: begin
                    if (req_i) begin
                        start_o <= ~misalign_in; // Bad alignment never starts.
                        state_q <= P_BUSY;
                    end
                end
                P_BUSY: begin
                    if (misalign_q || done_i) begin
                        state_q <= P_ACK;
                    end
                end
                default: begin
                    if (!req_i) begin
                        state_q <= P_IDLE; // Processor released the request.
                    end
                end
            endcase
        end
    end

    // Request fields and response, held for the whole handshake.
    always_ff @(posedge clk_i) begin
        if (state_q == P_IDLE && req_i) begin
            op_o       <= op_i;
            addr_o     <= addr_i;
            wdata_o    <= wdata_i;
            misalign_q <= misalign_in;
        end
        if (state_q == P_BUSY) begin
            rdata_o <= misalign_q ? '0 : rdata_i;
            hit_o   <= misalign_q ? 1'b0 : hit_i;
        end
    end

    assign ack_o      = (state_q == P_ACK);
    assign unalign_o  = misalign_q;
    assign misalign_o = misalign_q;

endmodule

// File: source/line_store.sv
// Line store: four cache lines with line fill and word or byte read.
`timescale 1ns/1ps

module line_store import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              fill_i,
    input  logic [WAY_W-1:0]  way_i,
    input  logic [OFFS_W-1:0] offs_i,
    input  logic              byte_i,
    input  logic [LINE_W-1:0] line_i,
    output logic [WORD_W-1:0] data_o
);

    logic [LINE_W-1:0] lines_q [NUM_WAYS];
    logic [LINE_W-1:0] line_sel;
    logic [WORD_W-1:0] word_sel;
    logic [7:0]        byte_sel;

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            lines_q[way_i] <= line_i;
        end
    end

    // Byte 0 of the line sits in the low bits.
    assign line_sel = lines_q[way_i];
    assign word_sel = line_sel[offs_i[OFFS_W-1:2] * WORD_W +: WORD_W];
    assign byte_sel = line_sel[offs_i * 8 +: 8];
    assign data_o   = byte_i ? {{(WORD_W - 8){1'b0}}, byte_sel} : word_sel;

endmodule

// File: source/mem_bus_pkg.sv
// Memory bus package: word and line widths of the memory-side port.

package mem_bus_pkg;

    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE; // 128 bits.

endpackage

// File: source/mem_port.sv
// Memory port: four-phase master for line fetches and word writes.
`timescale 1ns/1ps

module mem_port import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              fetch_i,
    input  logic              write_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [WORD_W-1:0] wdata_i,
    input  logic              mem_ack_i,
    input  logic [LINE_W-1:0] mem_line_i,
    output logic              done_o,
    output logic [LINE_W-1:0] line_o,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [WORD_W-1:0] mem_wdata_o
);

    typedef enum logic [1:0] {M_IDLE, M_REQ, M_RELEASE} mstate_e;

    mstate_e state_q;
    logic    launch;

    assign launch    = (state_q == M_IDLE) && (fetch_i || write_i);
    assign mem_req_o = (state_q == M_REQ);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= M_IDLE;
            mem_we_o <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                M_IDLE: begin
                    if (launch) begin
                        mem_we_o <= write_i;
                        state_q  <= M_REQ;
                    end
                end
                M_REQ: begin
                    if (mem_ack_i) begin
                        state_q <= M_RELEASE; // Drop the request.
                    end
                end
                default: begin
                    if (!mem_ack_i) begin
                        mem_we_o <= 1'b0;
                        done_o   <= 1'b1;     // Handshake closed.
                        state_q  <= M_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (launch) begin
            mem_addr_o  <= addr_i;
            mem_wdata_o <= wdata_i;
        end
        if (state_q == M_REQ && mem_ack_i) begin
            line_o <= mem_line_i; // Line is valid with the ack.
        end
    end

endmodule

// File: source/tag_lookup.sv
// Tag lookup: tag store, valid bits and age matrix with hit and victim selection.
`timescale 1ns/1ps

module tag_lookup import cache_geom_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic              lookup_i,
    input  logic              fill_i,
    input  logic              inval_i,
    input  logic [WAY_W-1:0]  way_i,
    input  logic [TAG_W-1:0]  tag_i,
    output logic              hit_o,
    output logic [WAY_W-1:0]  hit_way_o,
    output logic [WAY_W-1:0]  victim_o
);

    logic [TAG_W-1:0]    tags_q [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q;
    logic [NUM_WAYS-1:0] hit_vec;

    // age_q[x][y] set: way x is older than way y.
    // A row of all ones marks the oldest way.
    logic [NUM_WAYS-1:0] age_q [NUM_WAYS];

    logic                touch;
    logic [WAY_W-1:0]    touch_way;
    logic [WAY_W-1:0]    free_way;
    logic [WAY_W-1:0]    oldest_way;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare and select. Lowest index wins.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        hit_way_o  = '0;
        free_way   = '0;
        oldest_way = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            hit_vec[i] = valid_q[i] && (tags_q[i] == addr_i[ADDR_W-1:OFFS_W]);
            if (hit_vec[i]) begin
                hit_way_o = WAY_W'(i);
            end
            if (!valid_q[i]) begin
                free_way = WAY_W'(i);
            end
            if (&age_q[i]) begin
                oldest_way = WAY_W'(i);
            end
        end
    end

    assign hit_o    = |hit_vec;
    assign victim_o = (&valid_q) ? oldest_way : free_way;

    // Fill or read hit makes a way most recent.
    assign touch     = fill_i || (lookup_i && hit_o);
    assign touch_way = fill_i ? way_i : hit_way_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            for (int r = 0; r < NUM_WAYS; r++) begin
                age_q[r] <= '0;
            end
        end else begin
            if (fill_i) begin
                valid_q[way_i] <= 1'b1;
            end else if (inval_i) begin
                valid_q[way_i] <= 1'b0;
            end
            for (int n = 0; n < NUM_WAYS; n++) begin
                if (touch) begin
                    age_q[touch_way][n] <= 1'b0; // Younger than all.
                    age_q[n][touch_way] <= 1'b1;
                end else if (inval_i) begin
                    age_q[n][way_i] <= 1'b0;     // Older than all.
                    age_q[way_i][n] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tags_q[way_i] <= tag_i;
        end
    end

endmodule

// File: sources.f
source/cache_geom_pkg.sv
source/mem_bus_pkg.sv
source/cpu_port.sv
source/cache_ctrl.sv
source/tag_lookup.sv
source/line_store.sv
source/mem_port.sv
source/cache_top.sv
testbench/clock_gen.sv
testbench/mem_model.sv
testbench/tb_top.sv

// File: testbench/cache_stimulus.txt
# op addr wdata rdata hit unalign, all hex; op 0 read word, 1 read byte, 2 write word
# rdata is checked on aligned reads, hit on every aligned request
0 01230 00000000 A5A5048C 0 0
0 01238 00000000 A5A5048E 1 0
1 01235 00000000 00000004 1 0
1 0123F 00000000 000000A5 1 0
0 01232 00000000 00000000 0 1
2 01231 CAFEF00D 00000000 0 1
0 04564 00000000 A5A51159 0 0
0 78908 00000000 A5A4E242 0 0
0 ABCDC 00000000 A5A7AF37 0 0
0 0123C 00000000 A5A5048F 1 0
0 FFFF0 00000000 A5A6FFFC 0 0
0 01234 00000000 A5A5048D 1 0
0 04564 00000000 A5A51159 0 0
0 ABCD0 00000000 A5A7AF34 1 0
2 01238 DEADBEEF 00000000 1 0
0 01238 00000000 DEADBEEF 0 0
2 55550 12345678 00000000 0 0
0 55550 00000000 12345678 0 0
1 55553 00000000 00000012 1 0
1 0123A 00000000 000000AD 1 0

// File: testbench/clock_gen.sv
// Clock and reset source: 40 ns clock and a reset held for two rising edges.
`timescale 1ns/1ps

module clock_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD_NS = 20;
    localparam int RESET_CYCLES   = 2;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Reset drops on a falling edge, like the rest of the stimulus.
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// File: testbench/mem_model.sv
// Memory model: four-phase slave with a fixed fill rule and a table of written words.
`timescale 1ns/1ps

module mem_model import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              mem_req_i,
    input  logic              mem_we_i,
    input  logic [ADDR_W-1:0] mem_addr_i,
    input  logic [WORD_W-1:0] mem_wdata_i,
    output logic              mem_ack_o,
    output logic [LINE_W-1:0] mem_line_o
);

    localparam logic [WORD_W-1:0] FILL_KEY = 32'hA5A50000;

    logic [WORD_W-1:0] written [int]; // Word address to data.
    int                xacts = 0;

    // Unwritten words hold their own word address xor a key.
    function automatic logic [WORD_W-1:0] word_at(input int waddr);
        if (written.exists(waddr)) begin
            return written[waddr];
        end
        return WORD_W'(waddr) ^ FILL_KEY;
    endfunction

    function automatic logic [LINE_W-1:0] line_at(input int base);
        logic [LINE_W-1:0] data;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            data[k*WORD_W +: WORD_W] = word_at(base + k); // Word 0 in the low bits.
        end
        return data;
    endfunction

    // Acks on a falling edge after a latency that cycles through 1 to 3.
    initial begin
        mem_ack_o  = 1'b0;
        mem_line_o = '0;
        forever begin
            @(negedge clk_i);
            if (mem_req_i && !mem_ack_o) begin
                repeat (1 + xacts % 3) @(negedge clk_i);
                if (mem_we_i) begin
                    written[int'(mem_addr_i[ADDR_W-1:2])] = mem_wdata_i;
                end else begin
                    mem_line_o = line_at(int'(mem_addr_i[ADDR_W-1:2]));
                end
                mem_ack_o = 1'b1;
                xacts++;
            end else if (!mem_req_i && mem_ack_o) begin
                mem_ack_o = 1'b0; // Master released the request.
            end
        end
    end

endmodule

// File: testbench/tb_top.sv
// Cache testbench that replays the stimulus file through the cache and checks each response.
`timescale 1ns/1ps

module tb_top import cache_geom_pkg::*, mem_bus_pkg::*; ();

    localparam int CYCLES_PER_TEST = 200;

    logic              clk;
    logic              rst;
    logic              req;
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    logic              ack;
    logic [WORD_W-1:0] rdata;
    logic              hit;
    logic              unalign;
    logic              mem_req;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [WORD_W-1:0] mem_wdata;
    logic              mem_ack;
    logic [LINE_W-1:0] mem_line;

    // One entry per stimulus line.
    logic [1:0]        stim_op [$];
    logic [ADDR_W-1:0] stim_addr [$];
    logic [WORD_W-1:0] stim_wdata [$];
    logic [WORD_W-1:0] stim_rdata [$];
    logic              stim_hit [$];
    logic              stim_unal [$];

    int   errors       = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;
    int   cycles       = 0;
    int   cycle_limit  = CYCLES_PER_TEST;
    int   mem_xacts    = 0;
    logic mem_req_d    = 1'b0;

    clock_gen u_clock_gen (.clk_o(clk), .rst_o(rst));

    mem_model u_mem_model (
        .clk_i       (clk),
        .mem_req_i   (mem_req),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_ack_o   (mem_ack),
        .mem_line_o  (mem_line)
    );

    cache_top dut_i (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_i       (req),
        .op_i        (op),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .ack_o       (ack),
        .rdata_o     (rdata),
        .hit_o       (hit),
        .unalign_o   (unalign),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_ack_i   (mem_ack),
        .mem_line_i  (mem_line)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting and compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic print_counts();
        $display("Tests: %0d run, %0d passed, %0d failed; %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
    endtask

    task automatic end_with_failure(input string reason);
        $display("%s", reason);
        print_counts();
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic check_data(input string sig, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("Wrong number of %s: %0d seen, %0d expected", what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string label, input int errs_before);
        tests_run++;
        if (errors > errs_before) begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_run, label);
        end else begin
            $display("Test %0d %s: passed", tests_run, label);
        end
    endtask

    // Counts memory handshakes by their rising request.
    always @(negedge clk) begin
        mem_req_d <= mem_req;
        if (mem_req && !mem_req_d) begin
            mem_xacts <= mem_xacts + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            end_with_failure($sformatf("Timeout: run stopped after %0d cycles", cycles));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequences.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_reset_idle();
        int errs_before;
        errs_before = errors;
        wait (rst == 1'b0);
        repeat (4) begin
            @(negedge clk);
            check_flag("ack_o", ack, 1'b0);
            check_flag("mem_req_o", mem_req, 1'b0);
            check_flag("mem_we_o", mem_we, 1'b0);
        end
        report_test("reset idle", errs_before);
    endtask

    // Runs one four-phase handshake from a falling edge.
    task automatic run_request(input int idx);
        logic  is_read;
        int    errs_before;
        int    xacts_before;
        int    waited;
        int    exp_wait;
        int    exp_xacts;
        string label;
        errs_before  = errors;
        xacts_before = mem_xacts;
        is_read      = (stim_op[idx] != OP_WR_WORD);
        op           = op_e'(stim_op[idx]);
        addr         = stim_addr[idx];
        wdata        = stim_wdata[idx];
        req          = 1'b1;
        label        = $sformatf("%s addr %h", op.name(), stim_addr[idx]);

        // Misaligned requests take 2 cycles and read hits 3, with no memory traffic.
        if (stim_unal[idx]) begin
            exp_wait  = 2;
            exp_xacts = 0;
        end else if (is_read && stim_hit[idx]) begin
            exp_wait  = 3;
            exp_xacts = 0;
        end else begin
            exp_wait  = 0; // Memory sets the latency.
            exp_xacts = 1;
        end

        @(negedge clk);
        waited = 1;
        while (!ack) begin
            @(negedge clk);
            waited++;
        end
        if (exp_wait != 0) begin
            check_count("cycles from request to ack_o", waited, exp_wait);
        end
        check_flag("unalign_o", unalign, stim_unal[idx]);
        if (!stim_unal[idx]) begin
            check_flag("hit_o", hit, stim_hit[idx]);
            if (is_read) begin
                check_data("rdata_o", rdata, stim_rdata[idx]);
            end
        end

        req = 1'b0;
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
        end
        check_count("memory handshakes", mem_xacts - xacts_before, exp_xacts);
        report_test(label, errs_before);
    endtask

    initial begin
        int                fd;
        int                got;
        int                fields;
        string             text;
        logic [1:0]        f_op;
        logic [ADDR_W-1:0] f_addr;
        logic [WORD_W-1:0] f_wdata;
        logic [WORD_W-1:0] f_rdata;
        logic              f_hit;
        logic              f_unal;
        req   = 1'b0;
        op    = OP_RD_WORD;
        addr  = '0;
        wdata = '0;
        fd    = $fopen("testbench/cache_stimulus.txt", "r");
        if (fd == 0) begin
            end_with_failure("Cannot open testbench/cache_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(text, fd);
                if (got > 1 && text.getc(0) != 8'h23) begin // Skips comments.
                    fields = $sscanf(text, "%h %h %h %h %h %h",
                                     f_op, f_addr, f_wdata, f_rdata, f_hit, f_unal);
                    if (fields == 6) begin
                        stim_op.push_back(f_op);
                        stim_addr.push_back(f_addr);
                        stim_wdata.push_back(f_wdata);
                        stim_rdata.push_back(f_rdata);
                        stim_hit.push_back(f_hit);
                        stim_unal.push_back(f_unal);
                    end else begin
                        $display("Stimulus line could not be read: %s", text);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            cycle_limit = CYCLES_PER_TEST * (stim_op.size() + 1);

            check_reset_idle();
            for (int i = 0; i < stim_op.size(); i++) begin
                run_request(i);
            end

            print_counts();
            if (errors == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule
